// File: Makefile
# Verilator build and run of the joypad testbench

VERILATOR ?= verilator
TOP       ?= joypad_tb
FILELIST  ?= joypad_top.f
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
PASS_TEXT ?= Everything OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench into $(LOG) and check it"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST LOG BUILD_DIR"

test:
	$(VERILATOR) --binary --assert --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/joypad_pkg.sv
package joypad_pkg;

   // one bit per button, high while the button is held down
   typedef struct packed {
      logic a;
      logic b;
      logic select;
      logic start;
      logic up;
      logic down;
      logic left;
      logic right;
   } buttons_t;

   // APB request as seen by the joypad block
   typedef struct packed {
      logic [7:0] paddr;
      logic       psel;
      logic       penable;
      logic       pwrite;
      logic [7:0] pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [7:0] prdata;
      logic       pready;
      logic       pslverr;
   } apb_rsp_t;

   // register offsets
   localparam logic [7:0] P1_ADDR      = 8'h00;
   localparam logic [7:0] PAD_SEL_ADDR = 8'h04;
   localparam logic [7:0] RAW_ADDR     = 8'h08;
   localparam logic [7:0] IRQ_ADDR     = 8'h0C;

   // position of each button in the serial frame, bit 0 comes out during latch
   localparam logic [2:0] BIT_A      = 3'd0;
   localparam logic [2:0] BIT_B      = 3'd1;
   localparam logic [2:0] BIT_SELECT = 3'd2;
   localparam logic [2:0] BIT_START  = 3'd3;
   localparam logic [2:0] BIT_UP     = 3'd4;
   localparam logic [2:0] BIT_DOWN   = 3'd5;
   localparam logic [2:0] BIT_LEFT   = 3'd6;
   localparam logic [2:0] BIT_RIGHT  = 3'd7;

   localparam int PAD_BITS = 8; // bits per pad frame

endpackage

// File: design/joypad_regs.sv
`timescale 1ns/1ns

module joypad_regs #(
   parameter int NUM_PADS = 2
) (
   input  logic                 I_CLK,
   input  logic                 I_RESET,
   input  logic                 frame_done,
   input  joypad_pkg::buttons_t pads [NUM_PADS],
   input  joypad_pkg::apb_req_t apb_req,
   output joypad_pkg::apb_rsp_t apb_rsp,
   output logic                 irq
);

   logic                 access;
   logic                 wr_en;
   logic                 hit_p1;
   logic                 hit_sel;
   logic                 hit_raw;
   logic                 hit_irq;
   logic                 mapped;
   logic [1:0]           row_sel_q; // P1 bits 5:4, low selects a row
   logic [1:0]           pad_sel_q;
   logic [NUM_PADS-1:0]  irq_q;
   logic [NUM_PADS-1:0]  irq_set;
   logic [NUM_PADS-1:0]  irq_clr;
   logic                 done_d;
   logic [3:0]           p1_low;
   logic [7:0]           rdata;
   joypad_pkg::buttons_t sel_pad;
   joypad_pkg::buttons_t prev_q [NUM_PADS];

   // zero wait state access phase
   assign access  = apb_req.psel && apb_req.penable;
   assign wr_en   = access && apb_req.pwrite;
   assign hit_p1  = (apb_req.paddr == joypad_pkg::P1_ADDR);
   assign hit_sel = (apb_req.paddr == joypad_pkg::PAD_SEL_ADDR);
   assign hit_raw = (apb_req.paddr == joypad_pkg::RAW_ADDR);
   assign hit_irq = (apb_req.paddr == joypad_pkg::IRQ_ADDR);
   assign mapped  = hit_p1 || hit_sel || hit_raw || hit_irq;

   // a pad number past the last reader shows nothing pressed
   always_comb begin
      sel_pad = '0;
      for (int i = 0; i < NUM_PADS; i++) begin
         if (pad_sel_q == 2'(i)) sel_pad = pads[i];
      end
   end

   // P1 matrix, action row has priority when both rows are selected
   always_comb begin
      if (!row_sel_q[1]) begin
         p1_low = ~{sel_pad.start, sel_pad.select, sel_pad.b, sel_pad.a};
      end else if (!row_sel_q[0]) begin
         p1_low = ~{sel_pad.down, sel_pad.up, sel_pad.left, sel_pad.right};
      end else begin
         p1_low = 4'hF;
      end
   end

   always_comb begin
      rdata = 8'h00;
      if (hit_p1)  rdata = {2'b11, row_sel_q, p1_low};
      if (hit_sel) rdata = {6'b0, pad_sel_q};
      if (hit_raw) rdata = sel_pad;
      if (hit_irq) rdata = {{(8 - NUM_PADS){1'b0}}, irq_q};
   end

   assign apb_rsp.prdata  = rdata;
   assign apb_rsp.pready  = access;
   assign apb_rsp.pslverr = access && !mapped; // unmapped writes are dropped below

   always_ff @(posedge I_CLK) begin
      if (I_RESET) begin
         row_sel_q <= 2'b11;
         pad_sel_q <= 2'b00;
      end else if (wr_en) begin
         if (hit_p1)  row_sel_q <= apb_req.pwdata[5:4];
         if (hit_sel) pad_sel_q <= apb_req.pwdata[1:0];
      end
   end

   // readers publish on frame_done, so the new state is compared one cycle later
   always_comb begin
      for (int i = 0; i < NUM_PADS; i++) begin
         irq_set[i] = done_d && |(pads[i] & ~prev_q[i]);
      end
   end

   assign irq_clr = (wr_en && hit_irq) ? apb_req.pwdata[NUM_PADS-1:0] : '0;

   always_ff @(posedge I_CLK) begin
      if (I_RESET) begin
         done_d <= 1'b0;
         irq_q  <= '0;
         for (int i = 0; i < NUM_PADS; i++) prev_q[i] <= '0;
      end else begin
         done_d <= frame_done;
         irq_q  <= (irq_q & ~irq_clr) | irq_set; // a new press beats a clear
         if (done_d) begin
            for (int i = 0; i < NUM_PADS; i++) prev_q[i] <= pads[i];
         end
      end
   end

   assign irq = |irq_q;

endmodule

// File: design/joypad_top.sv
`timescale 1ns/1ns

module joypad_top #(
   parameter int NUM_PADS = 2,
   parameter int SCAN_DIV = 4
) (
   input  logic                 I_CLK,
   input  logic                 I_RESET,
   input  logic [NUM_PADS-1:0]  pad_data,
   output logic                 pad_latch,
   output logic                 pad_pulse,
   input  joypad_pkg::apb_req_t apb_req,
   output joypad_pkg::apb_rsp_t apb_rsp,
   output logic                 irq
);

   logic                 sample;
   logic                 frame_done;
   joypad_pkg::buttons_t pad_state [NUM_PADS];

   // one timer drives the latch and pulse lines of every pad
   pad_scan_timer #(
      .SCAN_DIV (SCAN_DIV)
   ) u_timer (
      .I_CLK      (I_CLK),
      .I_RESET    (I_RESET),
      .latch      (pad_latch),
      .pulse      (pad_pulse),
      .sample     (sample),
      .frame_done (frame_done)
   );

   for (genvar gi = 0; gi < NUM_PADS; gi++) begin : g_pad
      pad_reader u_reader (
         .I_CLK      (I_CLK),
         .I_RESET    (I_RESET),
         .sample     (sample),
         .frame_done (frame_done),
         .pad_data   (pad_data[gi]),
         .buttons    (pad_state[gi])
      );
   end

   joypad_regs #(
      .NUM_PADS (NUM_PADS)
   ) u_regs (
      .I_CLK      (I_CLK),
      .I_RESET    (I_RESET),
      .frame_done (frame_done),
      .pads       (pad_state),
      .apb_req    (apb_req),
      .apb_rsp    (apb_rsp),
      .irq        (irq)
   );

endmodule

// File: design/pad_reader.sv
`timescale 1ns/1ns

module pad_reader (
   input  logic                 I_CLK,
   input  logic                 I_RESET,
   input  logic                 sample,
   input  logic                 frame_done,
   input  logic                 pad_data,
   output joypad_pkg::buttons_t buttons
);

   // serial bit k ends up at shift_q[k] once the whole frame is in
   logic [joypad_pkg::PAD_BITS-1:0] shift_q;

   always_ff @(posedge I_CLK) begin
      if (sample) begin
         // the pad drives low for a pressed button
         shift_q <= {~pad_data, shift_q[joypad_pkg::PAD_BITS-1:1]};
      end
   end

   // the published state only moves at frame end, so a half shifted frame never shows
   always_ff @(posedge I_CLK) begin
      if (I_RESET) begin
         buttons <= '0;
      end else if (frame_done) begin
         buttons.a      <= shift_q[joypad_pkg::BIT_A];
         buttons.b      <= shift_q[joypad_pkg::BIT_B];
         buttons.select <= shift_q[joypad_pkg::BIT_SELECT];
         buttons.start  <= shift_q[joypad_pkg::BIT_START];
         buttons.up     <= shift_q[joypad_pkg::BIT_UP];
         buttons.down   <= shift_q[joypad_pkg::BIT_DOWN];
         buttons.left   <= shift_q[joypad_pkg::BIT_LEFT];
         buttons.right  <= shift_q[joypad_pkg::BIT_RIGHT];
      end
   end

endmodule

// File: design/pad_scan_timer.sv
`timescale 1ns/1ns

module pad_scan_timer #(
   parameter int SCAN_DIV = 4
) (
   input  logic I_CLK,
   input  logic I_RESET,
   output logic latch,
   output logic pulse,
   output logic sample,
   output logic frame_done
);

   // a frame is split into phases of SCAN_DIV cycles each
   //   phase 0        latch high
   //   phase 1        gap before the first pulse
   //   phases 2..15   seven pulses, high on even phases and low on odd ones
   //   phase 16       idle gap between frames
   localparam int CNT_W      = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
   localparam int IDLE_PHASE = 2 * joypad_pkg::PAD_BITS;
   localparam int PH_W       = $clog2(IDLE_PHASE + 1);

   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SCAN_DIV - 1);
   localparam logic [PH_W-1:0]  PH_IDLE  = PH_W'(IDLE_PHASE);
   localparam logic [PH_W-1:0]  PH_FIRST_PULSE = PH_W'(2);

   logic [CNT_W-1:0] cnt_q;
   logic [CNT_W-1:0] cnt_nxt;
   logic [PH_W-1:0]  phase_q;
   logic [PH_W-1:0]  phase_nxt;
   logic             sample_nxt;
   logic             pulse_nxt;

   always_comb begin
      if (cnt_q == CNT_LAST) begin
         cnt_nxt   = '0;
         phase_nxt = (phase_q == PH_IDLE) ? '0 : phase_q + 1'b1; // wrap into the next frame
      end else begin
         cnt_nxt   = cnt_q + 1'b1;
         phase_nxt = phase_q;
      end
   end

   // the outputs are decoded from the next state so they come straight from flops
   always_comb begin
      pulse_nxt = !phase_nxt[0] && (phase_nxt >= PH_FIRST_PULSE) && (phase_nxt < PH_IDLE);

      // data is stable at the end of latch and at the end of each low phase after a pulse
      sample_nxt = (cnt_nxt == CNT_LAST) &&
                   ((phase_nxt == '0) ||
                    (phase_nxt[0] && (phase_nxt > PH_FIRST_PULSE) && (phase_nxt < PH_IDLE)));
   end

   always_ff @(posedge I_CLK) begin
      if (I_RESET) begin
         cnt_q      <= CNT_LAST; // parked at the end of idle so latch starts right after reset
         phase_q    <= PH_IDLE;
         latch      <= 1'b0;
         pulse      <= 1'b0;
         sample     <= 1'b0;
         frame_done <= 1'b0;
      end else begin
         cnt_q      <= cnt_nxt;
         phase_q    <= phase_nxt;
         latch      <= (phase_nxt == '0);
         pulse      <= pulse_nxt;
         sample     <= sample_nxt;
         frame_done <= (phase_nxt == PH_IDLE) && (cnt_nxt == '0); // one cycle after the last sample
      end
   end

endmodule

// File: joypad_top.f
design/joypad_pkg.sv
design/pad_scan_timer.sv
design/pad_reader.sv
design/joypad_regs.sv
design/joypad_top.sv
tests/joypad_checker.sv
tests/joypad_tb.sv

// File: tests/joypad_checker.sv
`timescale 1ns/1ns

module joypad_checker (
   input logic                 I_CLK,
   input logic                 I_RESET,
   input logic                 pad_latch,
   input logic                 pad_pulse,
   input joypad_pkg::apb_req_t apb_req,
   input joypad_pkg::apb_rsp_t apb_rsp,
   input logic                 irq
);

   logic access;
   logic irq_write;
   int   fail_count = 0;

   assign access    = apb_req.psel && apb_req.penable;
   assign irq_write = access && apb_req.pwrite && (apb_req.paddr == joypad_pkg::IRQ_ADDR);

   // the pad treats latch and clock as separate phases
   a_latch_pulse: assert property (@(posedge I_CLK) disable iff (I_RESET)
      !(pad_latch && pad_pulse)) else begin
      $error("pad latch and pulse are high together");
      fail_count++;
   end

   a_pready: assert property (@(posedge I_CLK) disable iff (I_RESET)
      access |-> apb_rsp.pready) else begin
      $error("pready is low in an APB access cycle");
      fail_count++;
   end

   // only a write to IRQ may take irq down
   a_irq_sticky: assert property (@(posedge I_CLK) disable iff (I_RESET)
      irq && !irq_write |=> irq) else begin
      $error("irq fell without a write to IRQ");
      fail_count++;
   end

   a_first_latch: assert property (@(posedge I_CLK)
      $fell(I_RESET) |=> pad_latch) else begin
      $error("no latch in the cycle after reset");
      fail_count++;
   end

endmodule

// File: tests/joypad_patterns.txt
# name op addr_or_pad0 data_or_pad1 expected, values in hex, pad bytes in buttons_t order
# pads expects RAW of the selected pad, write expects pslverr, wait_frames counts latches
reset_p1      read        00 00 ff
reset_sel     read        04 00 00
reset_raw     read        08 00 00
reset_irq     read        0c 00 00
cap_a         pads        80 00 80
cap_b         pads        40 00 40
cap_select    pads        20 00 20
cap_start     pads        10 00 10
cap_up        pads        08 00 08
cap_down      pads        04 00 04
cap_left      pads        02 00 02
cap_right     pads        01 00 01
mix_pads      pads        a5 5a a5
sel_action    write       00 10 00
p1_action     read        00 00 da
sel_dir       write       00 20 00
p1_dir        read        00 00 e6
sel_none      write       00 30 00
p1_none       read        00 00 ff
pad_sel_1     write       04 01 00
sel_dir_1     write       00 20 00
p1_dir_1      read        00 00 e9
raw_pad_1     read        08 00 5a
irq_clear_all write       0c 03 00
irq_idle      read        0c 00 00
press_right_1 pads        a5 5b 5b
irq_set       read        0c 00 02
irq_clear     write       0c 02 00
irq_cleared   read        0c 00 00
hold_frames   wait_frames 02 00 00
irq_held      read        0c 00 00
bad_read      read        10 00 00
bad_write     write       10 ff 01
sel_kept      read        04 00 01
p1_kept       read        00 00 e8
irq_kept      read        0c 00 00
random_pads   random      00 00 00

// File: tests/joypad_tb.sv
`timescale 1ns/1ns

module joypad_tb;

   localparam int    NUM_PADS = 2;
   localparam int    SCAN_DIV = 4;
   localparam string PATTERNS = "tests/joypad_patterns.txt";

   logic                 I_CLK = 1'b0;
   logic                 I_RESET;
   logic [NUM_PADS-1:0]  pad_data = '1; // released pads idle high
   logic                 pad_latch;
   logic                 pad_pulse;
   joypad_pkg::apb_req_t apb_req;
   joypad_pkg::apb_rsp_t apb_rsp;
   logic                 irq;

   joypad_pkg::buttons_t pad_bytes [NUM_PADS]; // buttons each modelled pad holds down
   logic [7:0]           shift_out [NUM_PADS];
   logic [1:0]           row_sel = 2'b11; // own copy of the P1 row selects
   logic [1:0]           pad_sel = 2'b00;
   int                   cycles = 0;
   int                   limit = 0;
   int                   seed = 32'hb697_071c;
   int                   n_pass = 0;
   int                   n_fail = 0;
   logic                 test_bad;
   string                test_name;

   joypad_top #(.NUM_PADS(NUM_PADS), .SCAN_DIV(SCAN_DIV)) i_dut (.*);

   bind joypad_top joypad_checker u_checker (.*);

   always #50 I_CLK = ~I_CLK;

   always @(posedge I_CLK) begin
      cycles++;
      if (limit > 0 && cycles > limit) begin
         $display("timeout: the tests did not finish within %0d cycles", limit);
         $display("Something failed");
         $finish;
      end
   end

   // serial position k carries the button whose BIT_ constant is k
   function automatic logic [7:0] serial_of(input joypad_pkg::buttons_t b);
      logic [7:0] s;
      s[joypad_pkg::BIT_A]      = b.a;
      s[joypad_pkg::BIT_B]      = b.b;
      s[joypad_pkg::BIT_SELECT] = b.select;
      s[joypad_pkg::BIT_START]  = b.start;
      s[joypad_pkg::BIT_UP]     = b.up;
      s[joypad_pkg::BIT_DOWN]   = b.down;
      s[joypad_pkg::BIT_LEFT]   = b.left;
      s[joypad_pkg::BIT_RIGHT]  = b.right;
      return s;
   endfunction

   // shift register pad, loads on latch and moves on by one bit per rising pulse
   always @(posedge pad_latch or posedge pad_pulse) begin
      for (int p = 0; p < NUM_PADS; p++) begin
         if (pad_latch)
            shift_out[p] = serial_of(pad_bytes[p]);
         else
            shift_out[p] = {1'b0, shift_out[p][7:1]};
      end
      #10;
      for (int p = 0; p < NUM_PADS; p++) pad_data[p] = ~shift_out[p][0]; // active low
   end

   function automatic logic is_mapped(input logic [7:0] addr);
      return addr == joypad_pkg::P1_ADDR || addr == joypad_pkg::PAD_SEL_ADDR ||
             addr == joypad_pkg::RAW_ADDR || addr == joypad_pkg::IRQ_ADDR;
   endfunction

   // what P1 must read from the row selects and the modelled pad buttons
   function automatic logic [7:0] p1_model();
      joypad_pkg::buttons_t b;
      b = '0;
      for (int i = 0; i < NUM_PADS; i++) begin
         if (int'(pad_sel) == i) b = pad_bytes[i];
      end
      if (!row_sel[1]) return {2'b11, row_sel, ~{b.start, b.select, b.b, b.a}};
      if (!row_sel[0]) return {2'b11, row_sel, ~{b.down, b.up, b.left, b.right}};
      return 8'hFF;
   endfunction

   task automatic check_value(input string what, input logic [7:0] exp, input logic [7:0] act);
      assert (act === exp) else begin
         $display("error %s %s: expected %h, actual %h", test_name, what, exp, act);
         test_bad = 1'b1;
      end
   endtask

   task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [7:0] wdata,
                             output logic [7:0] rdata, output logic err);
      apb_req = '{paddr: addr, psel: 1'b1, penable: 1'b0, pwrite: wr, pwdata: wdata};
      @(posedge I_CLK);
      #10 apb_req.penable = 1'b1;
      @(negedge I_CLK);
      while (!apb_rsp.pready) @(negedge I_CLK);
      rdata = apb_rsp.prdata;
      err   = apb_rsp.pslverr;
      @(posedge I_CLK);
      #10 apb_req = '0;
      if (wr && addr == joypad_pkg::P1_ADDR) row_sel = wdata[5:4]; // write landed at that edge
      if (wr && addr == joypad_pkg::PAD_SEL_ADDR) pad_sel = wdata[1:0];
   endtask

   task automatic wait_latches(input int n);
      repeat (n) @(posedge pad_latch);
      @(posedge I_CLK);
      #10;
   endtask

   // random buttons on every pad, each pad checked through both P1 rows
   task automatic random_pads();
      logic [7:0] rdata;
      logic       err;
      for (int p = 0; p < NUM_PADS; p++) pad_bytes[p] = 8'($random(seed));
      wait_latches(2);
      for (int p = 0; p < NUM_PADS; p++) begin
         apb_access(1'b1, joypad_pkg::PAD_SEL_ADDR, 8'(p), rdata, err);
         apb_access(1'b1, joypad_pkg::P1_ADDR, 8'h10, rdata, err);
         apb_access(1'b0, joypad_pkg::P1_ADDR, 8'h00, rdata, err);
         check_value("p1 action", p1_model(), rdata);
         apb_access(1'b1, joypad_pkg::P1_ADDR, 8'h20, rdata, err);
         apb_access(1'b0, joypad_pkg::P1_ADDR, 8'h00, rdata, err);
         check_value("p1 direction", p1_model(), rdata);
      end
   endtask

   initial begin
      int         fd;
      int         count;
      int         chk_fails;
      string      op;
      string      rest;
      logic [7:0] addr;
      logic [7:0] data;
      logic [7:0] expected;
      logic [7:0] rdata;
      logic       err;
      I_RESET = 1'b1;
      apb_req = '0;
      for (int p = 0; p < NUM_PADS; p++) pad_bytes[p] = '0;
      count = 0;
      fd = $fopen(PATTERNS, "r");
      if (fd != 0) begin
         while ($fscanf(fd, "%s", test_name) == 1) begin
            void'($fgets(rest, fd));
            if (test_name[0] != "#") count++;
         end
         $fclose(fd);
         fd = $fopen(PATTERNS, "r");
      end
      limit = count * 3 * 17 * SCAN_DIV + 200; // three frame periods per line at most
      repeat (3) @(posedge I_CLK);
      #10 I_RESET = 1'b0;

      while (fd != 0 && $fscanf(fd, "%s", test_name) == 1) begin
         if (test_name[0] == "#") begin
            void'($fgets(rest, fd)); // column legend
         end else begin
            void'($fscanf(fd, "%s %h %h %h", op, addr, data, expected));
            test_bad = 1'b0;
            if (op == "pads") begin
               pad_bytes[0] = addr;
               pad_bytes[1] = data;
               wait_latches(2); // one frame to load, one to publish
               apb_access(1'b0, joypad_pkg::RAW_ADDR, 8'h00, rdata, err);
               check_value("raw", expected, rdata);
            end else if (op == "write") begin
               apb_access(1'b1, addr, data, rdata, err);
               check_value("pslverr", expected, 8'(err));
            end else if (op == "read") begin
               apb_access(1'b0, addr, 8'h00, rdata, err);
               check_value("prdata", expected, rdata);
               check_value("pslverr", 8'(!is_mapped(addr)), 8'(err));
               if (addr == joypad_pkg::P1_ADDR) check_value("p1 model", p1_model(), rdata);
               if (addr == joypad_pkg::IRQ_ADDR) check_value("irq pin", 8'(|expected), 8'(irq));
            end else if (op == "wait_frames") begin
               wait_latches(int'(addr));
            end else if (op == "random") begin
               random_pads();
            end else begin
               $display("test %s has an unknown operation %s", test_name, op);
               test_bad = 1'b1;
            end
            if (test_bad) n_fail++;
            else n_pass++;
            $display("test %s: %s", test_name, test_bad ? "fail" : "pass");
         end
      end
      if (n_pass + n_fail == 0) begin
         $display("no tests could be read from %s", PATTERNS);
         n_fail = 1;
      end
      chk_fails = i_dut.u_checker.fail_count;
      $display("%0d tests passed, %0d tests failed, %0d checker assertions failed",
               n_pass, n_fail, chk_fails);
      if (n_fail == 0 && chk_fails == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule
